/* Bender.yml */
package:
  name: dtpu_core

sources:
  # Design, in dependency order
  - design/dtpu_pkg.sv
  - design/mxu_if.sv
  - design/mac_row.sv
  - design/mxu_array.sv
  - design/control_unit.sv
  - design/dtpu_core.sv

  # Testbench, top module tb_dtpu_core
  - target: test
    files:
      - test/tb_dtpu_mem.sv
      - test/tb_dtpu_core.sv

/* build.f */
design/dtpu_pkg.sv
design/mxu_if.sv
design/mac_row.sv
design/mxu_array.sv
design/control_unit.sv
design/dtpu_core.sv
test/tb_dtpu_mem.sv
test/tb_dtpu_core.sv

/* design/control_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module control_unit (
  input  logic                          clk,
  input  logic                          aresetn,
  input  logic                          enable,
  // CSR block RAM
  output logic [dtpu_pkg::addr_w-1:0]   csr_address,
  output logic                          csr_ce,
  input  logic [dtpu_pkg::csr_w-1:0]    csr_dout,
  // Weight block RAM
  output logic [dtpu_pkg::addr_w-1:0]   wm_address,
  output logic                          wm_ce,
  // FIFOs
  input  logic                          infifo_is_empty,
  output logic                          infifo_read,
  input  logic                          outfifo_is_full,
  output logic                          outfifo_write,
  // Host handshake
  input  logic                          cs_start,
  input  logic                          cs_continue,
  output logic                          cs_done,
  output logic                          cs_idle,
  output logic                          cs_ready,
  // Operand register loads
  output logic                          load_data,
  output logic                          load_weights,
  output dtpu_pkg::state_e              state,
  mxu_if.ctrl                           mxu
);

  dtpu_pkg::state_e state_q;
  dtpu_pkg::state_e state_d;

  dtpu_pkg::precision_e data_type_q;
  // Vector count N
  logic [dtpu_pkg::csr_w-1:0] n_q;
  logic [dtpu_pkg::csr_w-1:0] rd_cnt_q;
  logic [dtpu_pkg::csr_w-1:0] wr_cnt_q;
  // Operand registers hold a live vector
  logic opnd_valid_q;

  logic advance;
  logic in_run;
  logic last_rd;
  logic last_wr;

  //////////////////////////////
  // Datapath decisions
  //////////////////////////////

  // Stall only on a result that cannot leave
  assign advance = enable && !(mxu.out_valid && outfifo_is_full);
  assign in_run  = (state_q == dtpu_pkg::st_stream) || (state_q == dtpu_pkg::st_drain);

  // N is at least 1 in stream and drain
  assign last_rd = (rd_cnt_q == n_q - 1'b1);
  assign last_wr = (wr_cnt_q == n_q - 1'b1);

  assign infifo_read = (state_q == dtpu_pkg::st_stream) && advance && !infifo_is_empty;
  assign outfifo_write = in_run && advance && mxu.out_valid;

  assign load_data    = infifo_read;
  assign load_weights = (state_q == dtpu_pkg::st_weight_ld);

  assign mxu.advance   = advance;
  assign mxu.in_valid  = opnd_valid_q;
  assign mxu.data_type = data_type_q;

  // CSR reads, type issued as start is taken, count from csr_type
  assign csr_ce = ((state_q == dtpu_pkg::st_idle) && cs_start) ||
                  (state_q == dtpu_pkg::st_csr_type);
  assign csr_address = (state_q == dtpu_pkg::st_csr_type) ? dtpu_pkg::csr_addr_count
                                                          : dtpu_pkg::csr_addr_type;

  // Single weight word at address 0
  assign wm_ce      = (state_q == dtpu_pkg::st_weight_rd);
  assign wm_address = '0;

  // Host side
  assign cs_ready = infifo_read && last_rd;
  assign cs_done  = (state_q == dtpu_pkg::st_done);
  assign cs_idle  = (state_q == dtpu_pkg::st_idle);
  assign state    = state_q;

  //////////////////////////////
  // Run FSM
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      dtpu_pkg::st_idle:      if (cs_start) state_d = dtpu_pkg::st_csr_type;
      dtpu_pkg::st_csr_type:  state_d = dtpu_pkg::st_csr_count;
      // csr_dout holds N here, empty run skips the stream
      dtpu_pkg::st_csr_count: state_d = (csr_dout == '0) ? dtpu_pkg::st_done
                                                          : dtpu_pkg::st_weight_rd;
      dtpu_pkg::st_weight_rd: state_d = dtpu_pkg::st_weight_ld;
      dtpu_pkg::st_weight_ld: state_d = dtpu_pkg::st_stream;
      dtpu_pkg::st_stream:    if (cs_ready) state_d = dtpu_pkg::st_drain;
      dtpu_pkg::st_drain:     if (outfifo_write && last_wr) state_d = dtpu_pkg::st_done;
      dtpu_pkg::st_done:      if (cs_continue) state_d = dtpu_pkg::st_idle;
      default:                state_d = dtpu_pkg::st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!aresetn) begin
      state_q      <= dtpu_pkg::st_idle;
      data_type_q  <= dtpu_pkg::prec_int4;
      n_q          <= '0;
      rd_cnt_q     <= '0;
      wr_cnt_q     <= '0;
      opnd_valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // Type byte arrives in csr_type
      if (state_q == dtpu_pkg::st_csr_type) begin
        data_type_q <= dtpu_pkg::precision_e'(csr_dout[0]);
      end
      if (state_q == dtpu_pkg::st_csr_count) begin
        n_q      <= csr_dout;
        rd_cnt_q <= '0;
        wr_cnt_q <= '0;
      end
      if (infifo_read) begin
        rd_cnt_q <= rd_cnt_q + 1'b1;
      end
      if (outfifo_write) begin
        wr_cnt_q <= wr_cnt_q + 1'b1;
      end
      // Bubble when nothing was read
      if (advance) begin
        opnd_valid_q <= infifo_read;
      end
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  a_no_read_empty: assert property (
    @(posedge clk) disable iff (!aresetn)
    infifo_read |-> !infifo_is_empty
  ) else $error("control_unit: infifo_read while empty");

  a_no_write_full: assert property (
    @(posedge clk) disable iff (!aresetn)
    outfifo_write |-> !outfifo_is_full
  ) else $error("control_unit: outfifo_write while full");

  // Last read happens only while streaming
  a_ready_in_stream: assert property (
    @(posedge clk) disable iff (!aresetn)
    cs_ready |-> (state_q == dtpu_pkg::st_stream)
  ) else $error("control_unit: cs_ready outside stream");

endmodule

`default_nettype wire

/* design/dtpu_core.sv */
`timescale 1ns/1ps
`default_nettype none

module dtpu_core (
  input  logic                          clk,
  input  logic                          aresetn,
  input  logic                          enable,
  // CSR block RAM
  output logic [dtpu_pkg::addr_w-1:0]   csr_address,
  output logic                          csr_clk,
  output logic [dtpu_pkg::csr_w-1:0]    csr_din,
  input  logic [dtpu_pkg::csr_w-1:0]    csr_dout,
  output logic                          csr_ce,
  output logic                          csr_reset,
  output logic                          csr_we,
  // Weight block RAM
  output logic [dtpu_pkg::addr_w-1:0]   wm_address,
  output logic                          wm_clk,
  output logic [dtpu_pkg::wmem_w-1:0]   wm_din,
  input  logic [dtpu_pkg::wmem_w-1:0]   wm_dout,
  output logic                          wm_ce,
  output logic                          wm_reset,
  output logic                          wm_we,
  // Input FIFO
  input  logic                          infifo_is_empty,
  input  logic [dtpu_pkg::fifo_w-1:0]   infifo_dout,
  output logic                          infifo_read,
  // Output FIFO
  input  logic                          outfifo_is_full,
  output logic [dtpu_pkg::fifo_w-1:0]   outfifo_din,
  output logic                          outfifo_write,
  // Host handshake
  input  logic                          cs_start,
  input  logic                          cs_continue,
  output logic                          cs_done,
  output logic                          cs_idle,
  output logic                          cs_ready,
  output logic [3:0]                    state
);

  localparam int act_bits = dtpu_pkg::columns * dtpu_pkg::lane_w;
  localparam int wgt_bits = dtpu_pkg::rows * act_bits;
  localparam int res_bits = dtpu_pkg::rows * dtpu_pkg::acc_w;

  mxu_if mxu ();

  dtpu_pkg::state_e state_i;
  logic load_data;
  logic load_weights;

  // Operand registers
  dtpu_pkg::lane_t [dtpu_pkg::columns-1:0] act_q;
  logic [wgt_bits-1:0] wgt_q;

  //////////////////////////////
  // Control and matrix unit
  //////////////////////////////

  control_unit u_control_unit (
    .clk             (clk),
    .aresetn         (aresetn),
    .enable          (enable),
    .csr_address     (csr_address),
    .csr_ce          (csr_ce),
    .csr_dout        (csr_dout),
    .wm_address      (wm_address),
    .wm_ce           (wm_ce),
    .infifo_is_empty (infifo_is_empty),
    .infifo_read     (infifo_read),
    .outfifo_is_full (outfifo_is_full),
    .outfifo_write   (outfifo_write),
    .cs_start        (cs_start),
    .cs_continue     (cs_continue),
    .cs_done         (cs_done),
    .cs_idle         (cs_idle),
    .cs_ready        (cs_ready),
    .load_data       (load_data),
    .load_weights    (load_weights),
    .state           (state_i),
    .mxu             (mxu)
  );

  mxu_array u_mxu_array (
    .clk     (clk),
    .aresetn (aresetn),
    .mxu     (mxu)
  );

  // Vector taken on the same edge as infifo_read
  always_ff @(posedge clk) begin
    if (load_data) begin
      act_q <= infifo_dout[act_bits-1:0];
    end
  end

  // wm_dout valid in weight_ld
  always_ff @(posedge clk) begin
    if (load_weights) begin
      wgt_q <= wm_dout[wgt_bits-1:0];
    end
  end

  assign mxu.activations = act_q;
  assign mxu.weights     = wgt_q;

  // Row r at offset r*acc_w, top bits zero
  assign outfifo_din = {{(dtpu_pkg::fifo_w-res_bits){1'b0}}, mxu.result};

  //////////////////////////////
  // Block RAM pins
  //////////////////////////////

  // Same clock domain as the core
  assign csr_clk   = clk;
  assign wm_clk    = clk;
  assign csr_reset = ~aresetn;
  assign wm_reset  = ~aresetn;
  // Read only
  assign csr_din   = '0;
  assign csr_we    = 1'b0;
  assign wm_din    = '0;
  assign wm_we     = 1'b0;

  // State shown one cycle late
  always_ff @(posedge clk) begin
    if (!aresetn) begin
      state <= dtpu_pkg::st_idle;
    end else begin
      state <= state_i;
    end
  end

endmodule

`default_nettype wire

/* design/dtpu_pkg.sv */
`default_nettype none

package dtpu_pkg;

  //////////////////////////////
  // Array geometry
  //////////////////////////////

  // Weight rows, one row sum each
  localparam int rows = 3;
  // Activation lanes per vector
  localparam int columns = 3;
  // Max lane width, int4
  localparam int lane_w = 4;
  // Row sum width in the output word
  localparam int acc_w = 16;

  //////////////////////////////
  // External data paths
  //////////////////////////////

  localparam int fifo_w = 64;
  localparam int wmem_w = 64;
  localparam int csr_w = 8;
  localparam int addr_w = 32;

  // CSR map
  localparam logic [addr_w-1:0] csr_addr_type = 32'd0;
  localparam logic [addr_w-1:0] csr_addr_count = 32'd1;

  // Only bit 0 of the CSR type byte counts
  typedef enum logic [0:0] {
    prec_int4 = 1'b0,
    prec_int2 = 1'b1
  } precision_e;

  // Run sequence, in order
  typedef enum logic [3:0] {
    st_idle,
    st_csr_type,
    st_csr_count,
    st_weight_rd,
    st_weight_ld,
    st_stream,
    st_drain,
    st_done
  } state_e;

  typedef logic [lane_w-1:0] lane_t;
  typedef logic signed [acc_w-1:0] row_sum_t;

endpackage

`default_nettype wire

/* design/mac_row.sv */
`timescale 1ns/1ps
`default_nettype none

module mac_row (
  input  logic                                    clk,
  input  logic                                    aresetn,
  input  logic                                    advance,
  input  dtpu_pkg::precision_e                    data_type,
  input  dtpu_pkg::lane_t [dtpu_pkg::columns-1:0] activations,
  input  dtpu_pkg::lane_t [dtpu_pkg::columns-1:0] weights,
  output dtpu_pkg::row_sum_t                      sum
);

  // One signed product per lane, stage 1
  logic signed [2*dtpu_pkg::lane_w-1:0] prod_q [dtpu_pkg::columns];
  // Adder tree output, into stage 2
  dtpu_pkg::row_sum_t sum_d;

  // Lane to signed value
  // int2 keeps only bits 1:0 and extends bit 1
  function automatic logic signed [dtpu_pkg::lane_w-1:0] sext_lane(
    input dtpu_pkg::lane_t    v,
    input dtpu_pkg::precision_e dt
  );
    if (dt == dtpu_pkg::prec_int2) begin
      return {{(dtpu_pkg::lane_w-2){v[1]}}, v[1:0]};
    end
    return v;
  endfunction

  // Stage 1, products
  always_ff @(posedge clk) begin
    if (!aresetn) begin
      for (int k = 0; k < dtpu_pkg::columns; k++) begin
        prod_q[k] <= '0;
      end
    end else if (advance) begin
      for (int k = 0; k < dtpu_pkg::columns; k++) begin
        prod_q[k] <= sext_lane(activations[k], data_type) * sext_lane(weights[k], data_type);
      end
    end
  end

  // All operands signed, so products sign extend to acc_w
  always_comb begin
    sum_d = '0;
    for (int k = 0; k < dtpu_pkg::columns; k++) begin
      sum_d = sum_d + prod_q[k];
    end
  end

  // Stage 2, row sum
  always_ff @(posedge clk) begin
    if (!aresetn) begin
      sum <= '0;
    end else if (advance) begin
      sum <= sum_d;
    end
  end

endmodule

`default_nettype wire

/* design/mxu_array.sv */
`timescale 1ns/1ps
`default_nettype none

module mxu_array (
  input logic clk,
  input logic aresetn,
  mxu_if.array mxu
);

  localparam int row_bits = dtpu_pkg::columns * dtpu_pkg::lane_w;

  // Row sums gathered from the rows, one driver each
  wire dtpu_pkg::row_sum_t [dtpu_pkg::rows-1:0] row_sums;

  // Valid shift, bit 0 = products, bit 1 = sums
  logic [1:0] valid_q;

  //////////////////////////////
  // Rows
  //////////////////////////////

  for (genvar r = 0; r < dtpu_pkg::rows; r++) begin : g_row
    // Row r weights, lane k at offset k*lane_w
    dtpu_pkg::lane_t [dtpu_pkg::columns-1:0] row_w;

    assign row_w = mxu.weights[r*row_bits +: row_bits];

    mac_row u_mac_row (
      .clk         (clk),
      .aresetn     (aresetn),
      .advance     (mxu.advance),
      .data_type   (mxu.data_type),
      .activations (mxu.activations),
      .weights     (row_w),
      .sum         (row_sums[r])
    );
  end

  assign mxu.result = row_sums;

  //////////////////////////////
  // Valid pipeline
  //////////////////////////////

  // Moves in lock step with the row registers
  always_ff @(posedge clk) begin
    if (!aresetn) begin
      valid_q <= 2'b00;
    end else if (mxu.advance) begin
      valid_q <= {valid_q[0], mxu.in_valid};
    end
  end

  assign mxu.out_valid = valid_q[1];

  // Control decisions hang off out_valid
  a_out_valid_known: assert property (
    @(posedge clk) disable iff (!aresetn)
    !$isunknown(mxu.out_valid)
  ) else $error("mxu_array: out_valid unknown");

endmodule

`default_nettype wire

/* design/mxu_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface mxu_if;

  // Pipeline control, from the control unit
  logic advance;
  logic in_valid;
  dtpu_pkg::precision_e data_type;

  // Operands, from the core operand registers
  dtpu_pkg::lane_t [dtpu_pkg::columns-1:0] activations;
  // Flat weight word, row r lane k at (r*columns+k)*lane_w
  logic [dtpu_pkg::rows*dtpu_pkg::columns*dtpu_pkg::lane_w-1:0] weights;

  // Array output
  logic out_valid;
  dtpu_pkg::row_sum_t [dtpu_pkg::rows-1:0] result;

  modport ctrl (
    output advance, in_valid, data_type,
    input  out_valid
  );

  modport array (
    input  advance, in_valid, data_type, activations, weights,
    output out_valid, result
  );

endinterface

`default_nettype wire

/* test/tb_dtpu_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dtpu_core;

  logic clk;
  logic aresetn;
  logic enable = 1'b1;
  logic cs_start;
  logic cs_continue;
  logic rand_mode = 1'b0;
  logic empty_force = 1'b0;
  logic full_force = 1'b0;

  logic [dtpu_pkg::addr_w-1:0] csr_address;
  logic [dtpu_pkg::addr_w-1:0] wm_address;
  logic [dtpu_pkg::csr_w-1:0] csr_din;
  logic [dtpu_pkg::csr_w-1:0] csr_dout;
  logic [dtpu_pkg::wmem_w-1:0] wm_din;
  logic [dtpu_pkg::wmem_w-1:0] wm_dout;
  logic [dtpu_pkg::fifo_w-1:0] infifo_dout;
  logic [dtpu_pkg::fifo_w-1:0] outfifo_din;
  logic csr_clk;
  logic csr_ce;
  logic csr_reset;
  logic csr_we;
  logic wm_clk;
  logic wm_ce;
  logic wm_reset;
  logic wm_we;
  logic infifo_is_empty;
  logic infifo_read;
  logic outfifo_is_full;
  logic outfifo_write;
  logic cs_done;
  logic cs_idle;
  logic cs_ready;
  logic [3:0] state;

  // Expected words, in write order
  logic [dtpu_pkg::fifo_w-1:0] exp_mem [0:255];
  logic [dtpu_pkg::fifo_w-1:0] exp_head;
  int exp_wr = 0;
  int exp_rd = 0;
  int write_cnt = 0;
  int ready_cnt = 0;
  int errors = 0;
  int tests = 0;
  int failed = 0;
  logic [31:0] lfsr = 32'h071f_4d4b;

  dtpu_core dtpu_core_i (
    .clk (clk), .aresetn (aresetn), .enable (enable),
    .csr_address (csr_address), .csr_clk (csr_clk), .csr_din (csr_din),
    .csr_dout (csr_dout), .csr_ce (csr_ce), .csr_reset (csr_reset), .csr_we (csr_we),
    .wm_address (wm_address), .wm_clk (wm_clk), .wm_din (wm_din),
    .wm_dout (wm_dout), .wm_ce (wm_ce), .wm_reset (wm_reset), .wm_we (wm_we),
    .infifo_is_empty (infifo_is_empty), .infifo_dout (infifo_dout),
    .infifo_read (infifo_read), .outfifo_is_full (outfifo_is_full),
    .outfifo_din (outfifo_din), .outfifo_write (outfifo_write),
    .cs_start (cs_start), .cs_continue (cs_continue), .cs_done (cs_done),
    .cs_idle (cs_idle), .cs_ready (cs_ready), .state (state)
  );

  tb_dtpu_mem mem_i (
    .clk (clk), .csr_clk (csr_clk), .csr_address (csr_address), .csr_ce (csr_ce),
    .csr_dout (csr_dout), .wm_clk (wm_clk), .wm_address (wm_address), .wm_ce (wm_ce),
    .wm_dout (wm_dout), .infifo_read (infifo_read), .infifo_dout (infifo_dout),
    .infifo_is_empty (infifo_is_empty), .outfifo_is_full (outfifo_is_full),
    .empty_force (empty_force), .full_force (full_force)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////
  // Random source and model
  //////////////////////////////

  // Galois LFSR, x^32+x^30+x^26+x^25+1
  function automatic logic next_bit();
    logic b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) begin
      lfsr = lfsr ^ 32'ha300_0000;
    end
    return b;
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[62:0], next_bit()};
    end
    return v;
  endfunction

  // Lane as a signed integer, int2 uses bits 1:0 only
  function automatic int lane_value(input logic [3:0] v, input logic prec);
    if (prec) begin
      return v[1] ? int'(v[1:0]) - 4 : int'(v[1:0]);
    end
    return v[3] ? int'(v) - 16 : int'(v);
  endfunction

  function automatic logic [63:0] ref_word(
    input logic [11:0] act,
    input logic [35:0] w,
    input logic        prec
  );
    logic [63:0] word;
    int s;
    word = '0;
    for (int r = 0; r < 3; r++) begin
      s = 0;
      for (int k = 0; k < 3; k++) begin
        s += lane_value(act[k*4 +: 4], prec) * lane_value(w[(r*3+k)*4 +: 4], prec);
      end
      word[r*16 +: 16] = s[15:0];
    end
    return word;
  endfunction

  // FIFO and enable stalls, three fresh bits per cycle
  always @(negedge clk) begin
    if (rand_mode) begin
      empty_force <= next_bit();
      full_force <= next_bit();
      enable <= next_bit();
    end else begin
      empty_force <= 1'b0;
      full_force <= 1'b0;
      enable <= 1'b1;
    end
  end

  always @(posedge clk) begin
    if (outfifo_write) begin
      write_cnt <= write_cnt + 1;
      exp_rd <= exp_rd + 1;
    end
    if (cs_ready) begin
      ready_cnt <= ready_cnt + 1;
    end
  end

  assign exp_head = exp_mem[exp_rd];

  //////////////////////////////
  // Checks
  //////////////////////////////

  a_word: assert property (@(posedge clk) disable iff (!aresetn)
    outfifo_write |-> (outfifo_din == exp_head))
  else begin
    errors++;
    $display("error outfifo_din got %h expected %h", $sampled(outfifo_din),
             $sampled(exp_head));
  end

  a_extra_word: assert property (@(posedge clk) disable iff (!aresetn)
    outfifo_write |-> (exp_rd < exp_wr))
  else begin
    errors++;
    $display("output word written with none expected");
  end

  a_read_empty: assert property (@(posedge clk) disable iff (!aresetn)
    infifo_read |-> !infifo_is_empty)
  else begin
    errors++;
    $display("input FIFO read while empty");
  end

  a_write_full: assert property (@(posedge clk) disable iff (!aresetn)
    outfifo_write |-> !outfifo_is_full)
  else begin
    errors++;
    $display("output FIFO written while full");
  end

  // Done holds until the host answers, then back to idle
  a_done_hold: assert property (@(posedge clk) disable iff (!aresetn)
    (cs_done && !cs_continue) |=> cs_done)
  else begin
    errors++;
    $display("cs_done dropped before cs_continue");
  end

  a_done_exit: assert property (@(posedge clk) disable iff (!aresetn)
    (cs_done && cs_continue) |=> cs_idle)
  else begin
    errors++;
    $display("core did not return to idle after cs_continue");
  end

  // Read only block RAMs, their reset follows the core reset
  a_ram_pins: assert property (@(posedge clk)
    (csr_reset == !aresetn) && (wm_reset == !aresetn) &&
    (csr_din == '0) && (wm_din == '0) && !csr_we && !wm_we)
  else begin
    errors++;
    $display("block RAM reset, data-in or write enable pins wrong");
  end

  //////////////////////////////
  // Sequence
  //////////////////////////////

  task automatic abort_run(input string why);
    $display("timeout waiting for %s", why);
    $display("** FAIL **");
    $finish;
  endtask

  task automatic wait_for_done(input string name);
    int cyc;
    cyc = 0;
    while (!cs_done && cyc < 3000) begin
      @(negedge clk);
      cyc++;
    end
    if (!cs_done) begin
      abort_run({"cs_done in ", name});
    end
  endtask

  task automatic wait_for_idle(input string name);
    int cyc;
    cyc = 0;
    while (!cs_idle && cyc < 20) begin
      @(negedge clk);
      cyc++;
    end
    if (!cs_idle) begin
      abort_run({"cs_idle in ", name});
    end
  endtask

  // State port trails the FSM by one cycle, config steps are fixed
  task automatic check_states(input int n);
    logic [3:0] seq [5];
    if (n > 0) begin
      seq = '{dtpu_pkg::st_csr_type, dtpu_pkg::st_csr_count, dtpu_pkg::st_weight_rd,
              dtpu_pkg::st_weight_ld, dtpu_pkg::st_stream};
    end else begin
      // Empty run goes straight to done and waits there
      seq = '{dtpu_pkg::st_csr_type, dtpu_pkg::st_csr_count, dtpu_pkg::st_done,
              dtpu_pkg::st_done, dtpu_pkg::st_done};
    end
    for (int i = 0; i < 5; i++) begin
      @(negedge clk);
      assert (state == seq[i])
      else begin
        errors++;
        $display("error state got %h expected %h", state, seq[i]);
      end
    end
  endtask

  task automatic report_test(input string name, input int err0);
    tests++;
    if (errors != err0) begin
      failed++;
      $display("test %s failed, %0d errors", name, errors - err0);
    end else begin
      $display("test %s ok", name);
    end
  endtask

  // One full run, N vectors, from cs_start to idle
  task automatic run_vectors(input string name, input logic prec, input int n,
                             input logic rnd);
    logic [63:0] w;
    logic [63:0] a;
    int err0;
    int wr0;
    int rdy0;
    err0 = errors;
    wr0 = write_cnt;
    rdy0 = ready_cnt;
    @(negedge clk);
    // Junk above the used bits must not matter
    w = rand_bits(36);
    w[63:36] = 28'h9e3_779b;
    mem_i.load_config({7'h15, prec}, n[7:0], w);
    for (int i = 0; i < n; i++) begin
      a = rand_bits(12);
      mem_i.push_input({52'h5_a5a5_a5a5_a5a5, a[11:0]});
      exp_mem[exp_wr] = ref_word(a[11:0], w[35:0], prec);
      exp_wr++;
    end
    rand_mode <= rnd;
    @(negedge clk);
    cs_start = 1'b1;
    @(negedge clk);
    cs_start = 1'b0;
    check_states(n);
    wait_for_done(name);
    repeat (3) @(negedge clk);
    cs_continue = 1'b1;
    @(negedge clk);
    cs_continue = 1'b0;
    rand_mode <= 1'b0;
    wait_for_idle(name);
    assert (write_cnt - wr0 == n)
    else begin
      errors++;
      $display("error outfifo_write count got %h expected %h", write_cnt - wr0, n);
    end
    assert (ready_cnt - rdy0 == ((n > 0) ? 1 : 0))
    else begin
      errors++;
      $display("error cs_ready pulses got %h expected %h", ready_cnt - rdy0, (n > 0));
    end
    report_test(name, err0);
  endtask

  initial begin
    int err0;
    aresetn = 1'b0;
    cs_start = 1'b0;
    cs_continue = 1'b0;
    repeat (5) @(negedge clk);
    aresetn = 1'b1;
    err0 = errors;
    assert (cs_idle && !cs_done && !cs_ready && !infifo_read && !outfifo_write &&
            !csr_ce && !wm_ce && !csr_we && !wm_we && (state == dtpu_pkg::st_idle))
    else begin
      errors++;
      $display("handshake outputs not at their reset values");
    end
    report_test("reset_defaults", err0);

    run_vectors("int4_stream", 1'b0, 16, 1'b0);
    run_vectors("int2_stream", 1'b1, 16, 1'b0);
    run_vectors("random_stalls", 1'b0, 24, 1'b1);
    run_vectors("empty_run", 1'b0, 0, 1'b0);

    $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* test/tb_dtpu_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dtpu_mem (
  input  logic                          clk,
  // CSR block RAM
  input  logic                          csr_clk,
  input  logic [dtpu_pkg::addr_w-1:0]   csr_address,
  input  logic                          csr_ce,
  output logic [dtpu_pkg::csr_w-1:0]    csr_dout,
  // Weight block RAM
  input  logic                          wm_clk,
  input  logic [dtpu_pkg::addr_w-1:0]   wm_address,
  input  logic                          wm_ce,
  output logic [dtpu_pkg::wmem_w-1:0]   wm_dout,
  // Input FIFO
  input  logic                          infifo_read,
  output logic [dtpu_pkg::fifo_w-1:0]   infifo_dout,
  output logic                          infifo_is_empty,
  // Output FIFO
  output logic                          outfifo_is_full,
  // Random stalls from the testbench
  input  logic                          empty_force,
  input  logic                          full_force
);

  // Four entries each, low address bits only
  logic [dtpu_pkg::csr_w-1:0]  csr_mem [0:3];
  logic [dtpu_pkg::wmem_w-1:0] wm_mem [0:3];
  logic [1:0] csr_addr_q = '0;
  logic [1:0] wm_addr_q = '0;
  logic csr_ce_q = 1'b0;
  logic wm_ce_q = 1'b0;

  // Input FIFO store, filled before each run
  logic [dtpu_pkg::fifo_w-1:0] in_mem [0:255];
  int in_wr = 0;
  int in_rd = 0;
  logic in_avail = 1'b0;

  initial begin
    csr_dout = '0;
    wm_dout = '0;
    infifo_dout = '0;
  end

  task automatic load_config(
    input logic [dtpu_pkg::csr_w-1:0]  dtype,
    input logic [dtpu_pkg::csr_w-1:0]  count,
    input logic [dtpu_pkg::wmem_w-1:0] weights
  );
    csr_mem[0] = dtype;
    csr_mem[1] = count;
    wm_mem[0] = weights;
  endtask

  task automatic push_input(input logic [dtpu_pkg::fifo_w-1:0] word);
    in_mem[in_wr] = word;
    in_wr = in_wr + 1;
  endtask

  // Requests taken on the rising edge of each RAM clock
  always @(posedge csr_clk) begin
    csr_ce_q <= csr_ce;
    csr_addr_q <= csr_address[1:0];
  end

  always @(posedge wm_clk) begin
    wm_ce_q <= wm_ce;
    wm_addr_q <= wm_address[1:0];
  end

  always @(posedge clk) begin
    if (infifo_read) begin
      in_rd <= in_rd + 1;
    end
  end

  // Data out on the falling edge, one cycle after ce
  always @(negedge csr_clk) begin
    if (csr_ce_q) begin
      csr_dout <= csr_mem[csr_addr_q];
    end
  end

  always @(negedge wm_clk) begin
    if (wm_ce_q) begin
      wm_dout <= wm_mem[wm_addr_q];
    end
  end

  always @(negedge clk) begin
    in_avail <= (in_rd < in_wr);
    infifo_dout <= in_mem[in_rd];
  end

  assign infifo_is_empty = !in_avail || empty_force;
  assign outfifo_is_full = full_force;

endmodule

`default_nettype wire
